// File: Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_debug_top
FILELIST = filelist.f
OBJDIR   = obj_dir
PASS_MSG = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_txclk,
  output logic o_rstn
);

  // 10 ns period
  initial begin
    o_txclk = 1'b0;
    forever #5 o_txclk = ~o_txclk;
  end

  // reset low for 8 cycles, released away from the rising edge
  initial begin
    o_rstn = 1'b0;
    repeat (8) @(posedge o_txclk);
    @(negedge o_txclk);
    o_rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_debug_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_top;

  localparam int NP         = dbg_pkg::PORT_NUM;
  localparam int DEPTH      = dbg_pkg::SAMPLE_DEPTH;
  localparam int WAIT_LIMIT = 2000;

  logic                               txclk;
  logic                               rstn;
  logic [31:0]                        rx_data;
  logic                               rx_valid;
  logic                               rx_last;
  logic [NP-1:0][dbg_pkg::PORT_W-1:0] probe;
  logic [31:0]                        tx_data;
  logic                               tx_valid;
  logic                               tx_last;

  int unsigned tick = 0;
  logic [31:0] word_q [$];
  logic        lastf_q [$];
  logic [31:0] frame_words [$];
  int          frames_done = 0;
  int          frames_taken = 0;
  logic        in_frame = 1'b0;
  logic        cmd_sent = 1'b0;
  logic        timed_out = 1'b0;
  logic [31:0] cap_base [NP];
  logic [31:0] probe_at_accept [NP];
  string       cur_test = "reset";
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  tb_clk_gen u_clk (
    .o_txclk (txclk),
    .o_rstn  (rstn)
  );

  debug_top dut (
    .i_txclk    (txclk),
    .i_rstn     (rstn),
    .i_rx_data  (rx_data),
    .i_rx_valid (rx_valid),
    .i_rx_last  (rx_last),
    .i_probe    (probe),
    .o_tx_data  (tx_data),
    .o_tx_valid (tx_valid),
    .o_tx_last  (tx_last)
  );

  // free-running probe counters from p*2000
  always @(negedge txclk) begin
    tick <= tick + 1;
  end

  for (genvar p = 0; p < NP; p++) begin : g_probe
    assign probe[p] = 32'(p * 2000) + tick;
  end

  // frame monitor
  always @(posedge txclk) begin
    if (!rstn) begin
      in_frame <= 1'b0;
    end else if (tx_valid) begin
      word_q.push_back(tx_data);
      lastf_q.push_back(tx_last);
      in_frame <= !tx_last;
      if (tx_last) begin
        frames_done <= frames_done + 1;
      end
    end
  end

  // ****************************************
  // protocol checks
  // ****************************************
  a_reset_idle: assert property (@(posedge txclk) disable iff (!rstn)
    !cmd_sent |-> (!tx_valid && !tx_last))
  else begin
    $display("CHECK FAILED %s: valid,last before any command expected 00 actual %b%b",
             cur_test, $sampled(tx_valid), $sampled(tx_last));
    errors++;
  end

  a_last_valid: assert property (@(posedge txclk) disable iff (!rstn)
    tx_last |-> tx_valid)
  else begin
    $display("last was raised without valid during test %s", cur_test);
    errors++;
  end

  a_frame_head: assert property (@(posedge txclk) disable iff (!rstn)
    (tx_valid && !in_frame) |-> (tx_data == 32'h0 || tx_data[31:8] == 24'hff0000))
  else begin
    $display("CHECK FAILED %s: frame head expected 00000000 or ff0000xx actual %h",
             cur_test, $sampled(tx_data));
    errors++;
  end

  // status head is always followed at once by the closing word
  a_status_end: assert property (@(posedge txclk) disable iff (!rstn)
    ($past(tx_valid) && !$past(in_frame) && $past(tx_data) == 32'h0)
    |-> (tx_valid && tx_last && tx_data == 32'hffff_ffff))
  else begin
    $display("CHECK FAILED %s: status end expected ffffffff with last actual %h last %b",
             cur_test, $sampled(tx_data), $sampled(tx_last));
    errors++;
  end

  // ****************************************
  // helpers
  // ****************************************
  task automatic report_timeout(input string what);
    $display("timeout in test %s while waiting for %s", cur_test, what);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic send_word(input logic [31:0] w, input logic is_last);
    int gap;
    gap = int'($urandom_range(3, 0));
    repeat (gap) @(negedge txclk);
    @(negedge txclk);
    rx_data  = w;
    rx_valid = 1'b1;
    rx_last  = is_last;
    cmd_sent = 1'b1;
    @(posedge txclk);
    for (int p = 0; p < NP; p++) begin
      probe_at_accept[p] = probe[p];
    end
    @(negedge txclk);
    rx_valid = 1'b0;
    rx_last  = 1'b0;
  endtask

  task automatic send_arm();
    send_word(32'h0100_0000, 1'b1);
    // first sample lands two cycles after the ARM word
    for (int p = 0; p < NP; p++) begin
      cap_base[p] = probe_at_accept[p] + 32'd2;
    end
  endtask

  task automatic send_read(input logic [2:0] mask, input int addr, input int nwords);
    send_word({8'h02, 21'h0, mask}, 1'b0);
    send_word({8'h00, 8'(addr), 8'h00, 8'(nwords - 1)}, 1'b1);
  endtask

  task automatic pop_frame();
    int   waited;
    logic got_last;
    waited = 0;
    while (!timed_out && frames_done == frames_taken && waited < WAIT_LIMIT) begin
      @(negedge txclk);
      waited++;
    end
    if (frames_done != frames_taken) begin
      frame_words.delete();
      got_last = 1'b0;
      while (!got_last && lastf_q.size() != 0) begin
        frame_words.push_back(word_q.pop_front());
        got_last = lastf_q.pop_front();
      end
      frames_taken++;
    end else if (!timed_out) begin
      report_timeout("a frame");
    end
  endtask

  task automatic take_status();
    pop_frame();
    if (!timed_out) begin
      check_word("status length", 32'd2, 32'(frame_words.size()));
      if (frame_words.size() == 2) begin
        check_word("status head", 32'h0000_0000, frame_words[0]);
        check_word("status end", 32'hffff_ffff, frame_words[1]);
      end
    end
  endtask

  task automatic take_data_frame(input int port, input int addr, input int nwords);
    logic [31:0] exp;
    pop_frame();
    if (!timed_out) begin
      check_word("frame length", 32'(nwords + 1), 32'(frame_words.size()));
      check_word("header", 32'hff00_0000 | 32'(port), frame_words[0]);
      for (int k = 0; k < nwords && k + 1 < frame_words.size(); k++) begin
        // addresses wrap modulo the memory depth
        exp = cap_base[port] + 32'((addr + k) % DEPTH);
        check_word($sformatf("port %0d word %0d", port, k), exp, frame_words[k + 1]);
      end
    end
  endtask

  task automatic stay_quiet(input int cycles);
    repeat (cycles) @(negedge txclk);
    if (!timed_out) begin
      check_word("stray words", 32'd0, 32'(word_q.size()));
    end
    word_q.delete();
    lastf_q.delete();
    frames_taken = frames_done;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
  endtask

  task automatic close_test();
    tests_run++;
    if (errors == test_errors) begin
      $display("test %-14s ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %-14s failed, %0d errors", cur_test, errors - test_errors);
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    int waited;
    void'($urandom(32'hfe86_3110));
    rx_data  = '0;
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    waited   = 0;
    while (rstn !== 1'b1 && waited < 100) begin
      @(negedge txclk);
      waited++;
    end
    if (rstn !== 1'b1) begin
      report_timeout("reset release");
    end

    start_test("reset_idle");
    stay_quiet(20);
    close_test();

    start_test("status_on_arm");
    send_arm();
    take_status();
    stay_quiet(30);
    close_test();

    start_test("single_read");
    send_read(3'b010, 5, 16);
    take_data_frame(1, 5, 16);
    stay_quiet(10);
    close_test();

    start_test("multi_mask");
    send_read(3'b111, 100, 8);
    for (int p = 0; p < NP; p++) begin
      take_data_frame(p, 100, 8);
    end
    send_read(3'b101, 40, 3);
    take_data_frame(0, 40, 3);
    take_data_frame(2, 40, 3);
    stay_quiet(10);
    close_test();

    start_test("wrap_extremes");
    send_read(3'b001, 250, 10);
    take_data_frame(0, 250, 10);
    send_read(3'b100, 0, 256);
    take_data_frame(2, 0, 256);
    send_read(3'b010, 255, 1);
    take_data_frame(1, 255, 1);
    stay_quiet(10);
    close_test();

    start_test("ignored_input");
    send_word(32'h0700_0007, 1'b1);
    // READ cut short before its argument
    send_word(32'h0200_0007, 1'b1);
    stay_quiet(100);
    send_read(3'b001, 17, 4);
    take_data_frame(0, 17, 4);
    stay_quiet(20);
    close_test();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/dbg_pkg.sv
hdl/capture_rd_if.sv
hdl/cmd_decoder.sv
hdl/probe_capture.sv
hdl/port_arbiter.sv
hdl/tx_framer.sv
hdl/debug_top.sv
dv/tb_clk_gen.sv
dv/tb_debug_top.sv

// File: hdl/capture_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface capture_rd_if;

  // sel from the arbiter, stream back from the capture block
  logic                       sel;
  logic                       valid;
  logic [dbg_pkg::PORT_W-1:0] data;
  logic                       last;

  modport cap (input sel, output valid, output data, output last);

  modport arb (output sel, input valid, input data, input last);

endinterface

`default_nettype wire

// File: hdl/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
  input  logic                        i_txclk,
  input  logic                        i_rstn,
  input  logic [31:0]                 i_rx_data,
  input  logic                        i_rx_valid,
  input  logic                        i_rx_last,
  output logic                        o_arm,
  output logic                        o_read_req,
  output logic [dbg_pkg::PORT_NUM-1:0] o_read_mask,
  output logic [dbg_pkg::ADDR_W-1:0]   o_rd_addr,
  output logic [dbg_pkg::ADDR_W-1:0]   o_rd_count
);

  dbg_pkg::dec_state_e state;
  dbg_pkg::cmd_op_e    opcode;

  // opcode sits in the top byte of a command word
  assign opcode = dbg_pkg::cmd_op_e'(i_rx_data[31:24]);

  // ****************************************
  // command FSM
  // ****************************************
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      state      <= dbg_pkg::DEC_CMD;
      o_arm      <= 1'b0;
      o_read_req <= 1'b0;
    end else begin
      o_arm      <= 1'b0;
      o_read_req <= 1'b0;
      if (i_rx_valid) begin
        case (state)
          dbg_pkg::DEC_CMD: begin
            if (opcode == dbg_pkg::OP_ARM) begin
              o_arm <= 1'b1;
            end else if (opcode == dbg_pkg::OP_READ && !i_rx_last) begin
              // a READ ended by last here never gets its argument
              state <= dbg_pkg::DEC_ARG;
            end
          end
          dbg_pkg::DEC_ARG: begin
            o_read_req <= 1'b1;
            state      <= dbg_pkg::DEC_CMD;
          end
          default: begin
            state <= dbg_pkg::DEC_CMD;
          end
        endcase
      end
    end
  end

  // read arguments, held until the next READ
  always_ff @(posedge i_txclk) begin
    if (i_rx_valid && state == dbg_pkg::DEC_CMD && opcode == dbg_pkg::OP_READ) begin
      o_read_mask <= i_rx_data[dbg_pkg::PORT_NUM-1:0];
    end
    if (i_rx_valid && state == dbg_pkg::DEC_ARG) begin
      o_rd_addr  <= i_rx_data[23:16];
      o_rd_count <= i_rx_data[7:0];
    end
  end

endmodule

`default_nettype wire

// File: hdl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  // ****************************************
  // sizes
  // ****************************************
  localparam int PORT_NUM     = 3;
  localparam int PORT_W       = 32;
  localparam int SAMPLE_DEPTH = 256;
  localparam int ADDR_W       = 8;
  localparam int PORT_IDX_W   = 2;

  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // ****************************************
  // frame words
  // ****************************************
  // low byte of the data header carries the port index
  localparam logic [31:0] HEAD_DATA   = 32'hff00_0000;
  localparam logic [31:0] STATUS_HEAD = 32'h0000_0000;
  localparam logic [31:0] STATUS_END  = 32'hffff_ffff;

  typedef enum logic [7:0] {
    OP_ARM  = 8'h01,
    OP_READ = 8'h02
  } cmd_op_e;

  typedef enum logic {DEC_CMD, DEC_ARG} dec_state_e;

  typedef enum logic [1:0] {CAP_IDLE, CAP_FILL, CAP_READ} cap_state_e;

  typedef enum logic [1:0] {TX_IDLE, TX_STATUS_END, TX_PORTDATA} tx_state_e;

endpackage

`default_nettype wire

// File: hdl/debug_top.sv
`timescale 1ns/1ps
`default_nettype none

module debug_top (
  input  logic                                              i_txclk,
  input  logic                                              i_rstn,
  input  logic [31:0]                                       i_rx_data,
  input  logic                                              i_rx_valid,
  input  logic                                              i_rx_last,
  input  logic [dbg_pkg::PORT_NUM-1:0][dbg_pkg::PORT_W-1:0] i_probe,
  output logic [31:0]                                       o_tx_data,
  output logic                                              o_tx_valid,
  output logic                                              o_tx_last
);

  logic                         arm;
  logic                         read_req;
  logic [dbg_pkg::PORT_NUM-1:0] read_mask;
  logic [dbg_pkg::ADDR_W-1:0]   rd_addr;
  logic [dbg_pkg::ADDR_W-1:0]   rd_count;
  logic [dbg_pkg::PORT_NUM-1:0] done;
  logic                         tx_idle;
  logic                         start;
  dbg_pkg::port_idx_t           port_idx;
  logic [dbg_pkg::PORT_W-1:0]   arb_data;
  logic                         arb_valid;
  logic                         arb_last;

  capture_rd_if rd_if [dbg_pkg::PORT_NUM] ();

  cmd_decoder u_dec (
    .i_txclk     (i_txclk),
    .i_rstn      (i_rstn),
    .i_rx_data   (i_rx_data),
    .i_rx_valid  (i_rx_valid),
    .i_rx_last   (i_rx_last),
    .o_arm       (arm),
    .o_read_req  (read_req),
    .o_read_mask (read_mask),
    .o_rd_addr   (rd_addr),
    .o_rd_count  (rd_count)
  );

  // one capture engine per probe port
  for (genvar i = 0; i < dbg_pkg::PORT_NUM; i++) begin : g_cap
    probe_capture u_cap (
      .i_txclk    (i_txclk),
      .i_rstn     (i_rstn),
      .i_probe    (i_probe[i]),
      .i_arm      (arm),
      .i_rd_addr  (rd_addr),
      .i_rd_count (rd_count),
      .o_done     (done[i]),
      .rd         (rd_if[i])
    );
  end

  port_arbiter u_arb (
    .i_txclk     (i_txclk),
    .i_rstn      (i_rstn),
    .i_read_req  (read_req),
    .i_read_mask (read_mask),
    .i_tx_idle   (tx_idle),
    .rd          (rd_if),
    .o_start     (start),
    .o_port_idx  (port_idx),
    .o_data      (arb_data),
    .o_valid     (arb_valid),
    .o_last      (arb_last)
  );

  tx_framer u_tx (
    .i_txclk    (i_txclk),
    .i_rstn     (i_rstn),
    .i_done     (done),
    .i_start    (start),
    .i_port_idx (port_idx),
    .i_data     (arb_data),
    .i_valid    (arb_valid),
    .i_last     (arb_last),
    .o_idle     (tx_idle),
    .o_tx_data  (o_tx_data),
    .o_tx_valid (o_tx_valid),
    .o_tx_last  (o_tx_last)
  );

endmodule

`default_nettype wire

// File: hdl/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
  input  logic                         i_txclk,
  input  logic                         i_rstn,
  input  logic                         i_read_req,
  input  logic [dbg_pkg::PORT_NUM-1:0] i_read_mask,
  input  logic                         i_tx_idle,
  capture_rd_if.arb                    rd [dbg_pkg::PORT_NUM],
  output logic                         o_start,
  output dbg_pkg::port_idx_t           o_port_idx,
  output logic [dbg_pkg::PORT_W-1:0]   o_data,
  output logic                         o_valid,
  output logic                         o_last
);

  logic [dbg_pkg::PORT_NUM-1:0] pending;
  logic [dbg_pkg::PORT_NUM-1:0] pending_nxt;
  logic [dbg_pkg::PORT_NUM-1:0] grant;
  logic [dbg_pkg::PORT_NUM-1:0] port_valid;
  logic [dbg_pkg::PORT_NUM-1:0] port_last;
  logic [dbg_pkg::PORT_W-1:0]   port_data [dbg_pkg::PORT_NUM];
  dbg_pkg::port_idx_t           next_idx;
  logic                         found;
  logic                         busy;
  logic                         cur_end;

  // flatten the interface array
  for (genvar p = 0; p < dbg_pkg::PORT_NUM; p++) begin : g_port
    assign rd[p].sel     = grant[p];
    assign port_valid[p] = rd[p].valid;
    assign port_last[p]  = rd[p].last;
    assign port_data[p]  = rd[p].data;
  end

  assign busy    = |grant;
  assign cur_end = busy && port_valid[o_port_idx] && port_last[o_port_idx];

  // lowest pending port wins
  always_comb begin
    next_idx = '0;
    found    = 1'b0;
    for (int p = dbg_pkg::PORT_NUM - 1; p >= 0; p--) begin
      if (pending[p]) begin
        next_idx = dbg_pkg::port_idx_t'(p);
        found    = 1'b1;
      end
    end
  end

  // a new request in the same cycle as last is kept
  always_comb begin
    pending_nxt = pending;
    if (cur_end) begin
      pending_nxt[o_port_idx] = 1'b0;
    end
    if (i_read_req) begin
      pending_nxt = pending_nxt | i_read_mask;
    end
  end

  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      pending    <= '0;
      grant      <= '0;
      o_port_idx <= '0;
      o_start    <= 1'b0;
      o_valid    <= 1'b0;
      o_last     <= 1'b0;
    end else begin
      pending <= pending_nxt;
      o_start <= 1'b0;
      if (busy) begin
        if (cur_end) begin
          grant <= '0;
        end
      end else if (i_tx_idle && found) begin
        grant           <= '0;
        grant[next_idx] <= 1'b1;
        o_port_idx      <= next_idx;
        o_start         <= 1'b1;
      end
      o_valid <= busy && port_valid[o_port_idx];
      o_last  <= cur_end;
    end
  end

  always_ff @(posedge i_txclk) begin
    o_data <= port_data[o_port_idx];
  end

endmodule

`default_nettype wire

// File: hdl/probe_capture.sv
`timescale 1ns/1ps
`default_nettype none

module probe_capture (
  input  logic                        i_txclk,
  input  logic                        i_rstn,
  input  logic [dbg_pkg::PORT_W-1:0]  i_probe,
  input  logic                        i_arm,
  input  logic [dbg_pkg::ADDR_W-1:0]  i_rd_addr,
  input  logic [dbg_pkg::ADDR_W-1:0]  i_rd_count,
  output logic                        o_done,
  capture_rd_if.cap                   rd
);

  logic [dbg_pkg::PORT_W-1:0] mem [dbg_pkg::SAMPLE_DEPTH];

  dbg_pkg::cap_state_e        state;
  logic [dbg_pkg::ADDR_W-1:0] wr_addr;
  logic [dbg_pkg::ADDR_W-1:0] rd_ptr;
  logic [dbg_pkg::ADDR_W-1:0] rd_left;
  logic                       served;
  logic                       valid_q;
  logic                       last_q;
  logic [dbg_pkg::PORT_W-1:0] rd_data_q;

  assign rd.valid = valid_q;
  assign rd.last  = last_q;
  assign rd.data  = rd_data_q;

  // ****************************************
  // sample memory
  // ****************************************
  always_ff @(posedge i_txclk) begin
    if (state == dbg_pkg::CAP_FILL) begin
      mem[wr_addr] <= i_probe;
    end
    // synchronous read, data lands one cycle after the address
    if (state == dbg_pkg::CAP_READ) begin
      rd_data_q <= mem[rd_ptr];
    end
  end

  // ****************************************
  // fill and readout control
  // ****************************************
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      state   <= dbg_pkg::CAP_IDLE;
      wr_addr <= '0;
      rd_ptr  <= '0;
      rd_left <= '0;
      served  <= 1'b0;
      o_done  <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      o_done  <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      // sel stays high a little after last, don't answer it twice
      if (!rd.sel) begin
        served <= 1'b0;
      end
      case (state)
        dbg_pkg::CAP_IDLE: begin
          if (i_arm) begin
            state   <= dbg_pkg::CAP_FILL;
            wr_addr <= '0;
          end else if (rd.sel && !served) begin
            state   <= dbg_pkg::CAP_READ;
            rd_ptr  <= i_rd_addr;
            rd_left <= i_rd_count;
          end
        end
        dbg_pkg::CAP_FILL: begin
          if (i_arm) begin
            wr_addr <= '0;
          end else begin
            wr_addr <= wr_addr + 1'b1;
            if (&wr_addr) begin
              state  <= dbg_pkg::CAP_IDLE;
              o_done <= 1'b1;
            end
          end
        end
        dbg_pkg::CAP_READ: begin
          valid_q <= 1'b1;
          last_q  <= (rd_left == '0);
          // pointer wraps modulo the depth
          rd_ptr  <= rd_ptr + 1'b1;
          rd_left <= rd_left - 1'b1;
          if (rd_left == '0) begin
            state  <= dbg_pkg::CAP_IDLE;
            served <= 1'b1;
          end
        end
        default: begin
          state <= dbg_pkg::CAP_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_framer (
  input  logic                         i_txclk,
  input  logic                         i_rstn,
  input  logic [dbg_pkg::PORT_NUM-1:0] i_done,
  input  logic                         i_start,
  input  dbg_pkg::port_idx_t           i_port_idx,
  input  logic [dbg_pkg::PORT_W-1:0]   i_data,
  input  logic                         i_valid,
  input  logic                         i_last,
  output logic                         o_idle,
  output logic [31:0]                  o_tx_data,
  output logic                         o_tx_valid,
  output logic                         o_tx_last
);

  dbg_pkg::tx_state_e           state;
  logic [dbg_pkg::PORT_NUM-1:0] done_seen;
  logic                         all_done;

  assign all_done = &done_seen;

  // not idle when a status frame is due next cycle, so start never collides
  assign o_idle = (state == dbg_pkg::TX_IDLE) && !(&(done_seen | i_done));

  // done bits since the last status frame
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      done_seen <= '0;
    end else if (state == dbg_pkg::TX_IDLE && all_done) begin
      done_seen <= i_done;
    end else begin
      done_seen <= done_seen | i_done;
    end
  end

  // ****************************************
  // frame FSM
  // ****************************************
  always_ff @(posedge i_txclk or negedge i_rstn) begin
    if (!i_rstn) begin
      state      <= dbg_pkg::TX_IDLE;
      o_tx_data  <= '0;
      o_tx_valid <= 1'b0;
      o_tx_last  <= 1'b0;
    end else begin
      case (state)
        dbg_pkg::TX_IDLE: begin
          if (all_done) begin
            o_tx_data  <= dbg_pkg::STATUS_HEAD;
            o_tx_valid <= 1'b1;
            o_tx_last  <= 1'b0;
            state      <= dbg_pkg::TX_STATUS_END;
          end else if (i_start) begin
            o_tx_data  <= dbg_pkg::HEAD_DATA | 32'(i_port_idx);
            o_tx_valid <= 1'b1;
            o_tx_last  <= 1'b0;
            state      <= dbg_pkg::TX_PORTDATA;
          end else begin
            o_tx_valid <= 1'b0;
            o_tx_last  <= 1'b0;
          end
        end
        dbg_pkg::TX_STATUS_END: begin
          o_tx_data  <= dbg_pkg::STATUS_END;
          o_tx_valid <= 1'b1;
          o_tx_last  <= 1'b1;
          state      <= dbg_pkg::TX_IDLE;
        end
        dbg_pkg::TX_PORTDATA: begin
          // gaps before the first port word pass through as invalid cycles
          o_tx_data  <= i_data;
          o_tx_valid <= i_valid;
          o_tx_last  <= i_valid && i_last;
          if (i_valid && i_last) begin
            state <= dbg_pkg::TX_IDLE;
          end
        end
        default: begin
          state <= dbg_pkg::TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire
